// ==== hdl/pgm_video_pkg.sv ====
// video stream beat types, packet codes, lfsr and trace word layout for the pixel grabber
package pgm_video_pkg;

    // input beat geometry
    localparam int num_pixels  = 3;
    localparam int pixel_width = 8;
    localparam int beat_width  = num_pixels * pixel_width;

    // one beat, seen either as pixels or as a control word
    typedef union packed {
        logic [num_pixels-1:0][pixel_width-1:0] pixels;
        struct packed {
            logic [beat_width-5:0] rest;
            // low nibble of pixel 0 on the sop beat
            logic [3:0]            pkt_type;
        } ctrl;
    } pixel_beat_u;

    // packet type nibble codes
    localparam logic [3:0] pkt_type_ctrl = 4'hf;
    localparam logic [3:0] pkt_type_data = 4'h0;

    // width, height and interlace nibbles of a control packet
    localparam int ctrl_nibbles = 9;

    // sampler field widths
    localparam int gap_width   = 14;
    localparam int index_width = 16;
    localparam int frame_width = 7;

    // prbs31, taps 31 and 28
    localparam int                    lfsr_width = 31;
    localparam logic [lfsr_width-1:0] lfsr_seed  = 31'd1;

    // trace packet shape
    localparam int         trace_width = 32;
    localparam int         trace_words = 4;
    // header byte with no flags set
    localparam logic [7:0] hdr_base    = 8'h80;

endpackage

// ==== hdl/pgm_csr_pkg.sv ====
// register map, identity values and control field positions of the pixel grabber
package pgm_csr_pkg;

    // bus geometry
    localparam int csr_addr_width = 4;
    localparam int csr_data_width = 32;

    // ********************************************************
    // register addresses
    // ********************************************************
    // identity word, read only
    localparam logic [csr_addr_width-1:0] csr_addr_id   = 4'd0;
    // build configuration, read only
    localparam logic [csr_addr_width-1:0] csr_addr_cfg  = 4'd2;
    // enable in bit 0
    localparam logic [csr_addr_width-1:0] csr_addr_ctrl = 4'd4;
    // lfsr mask and minimum gap
    localparam logic [csr_addr_width-1:0] csr_addr_gap  = 4'd5;

    // identity fields
    localparam logic [10:0] mfgr_id  = 11'd110;
    localparam logic [15:0] type_num = 16'd272;

    // minimum gap sits in the upper half of the gap register
    localparam int gap_min_lsb = 16;

endpackage

// ==== hdl/pgm_csr.sv ====
// register file of the pixel grabber: bus capture, enable, mask and minimum gap fields
`timescale 1ns/100ps

module pgm_csr (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   csr_write,
    input  logic                                   csr_read,
    input  logic [pgm_csr_pkg::csr_addr_width-1:0] csr_address,
    input  logic [pgm_csr_pkg::csr_data_width-1:0] csr_write_data,
    output logic [pgm_csr_pkg::csr_data_width-1:0] csr_readdata,
    output logic                                   enable,
    output logic [pgm_video_pkg::gap_width-1:0]    lfsr_mask,
    output logic [pgm_video_pkg::gap_width-1:0]    gap_min
);
    import pgm_csr_pkg::*;
    import pgm_video_pkg::*;

    logic                      wr_q;
    logic                      rd_q;
    logic [csr_addr_width-1:0] addr_q;
    logic [csr_data_width-1:0] wdata_q;
    logic [csr_data_width-1:0] rd_word;

    // strobes registered once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else begin
            wr_q <= csr_write;
            rd_q <= csr_read;
        end
    end

    // address and data follow the strobes
    always_ff @(posedge clk) begin
        addr_q  <= csr_address;
        wdata_q <= csr_write_data;
    end

    // writable fields, two edges after the write strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable    <= 1'b0;
            lfsr_mask <= '0;
            gap_min   <= '0;
        end else if (wr_q) begin
            if (addr_q == csr_addr_ctrl) begin
                enable <= wdata_q[0];
            end
            if (addr_q == csr_addr_gap) begin
                lfsr_mask <= wdata_q[0 +: gap_width];
                gap_min   <= wdata_q[gap_min_lsb +: gap_width];
            end
        end
    end

    // read mux, unused addresses give zero
    always_comb begin
        rd_word = '0;
        case (addr_q)
            csr_addr_id:   rd_word = {4'h0, type_num, 1'b0, mfgr_id};
            csr_addr_cfg:  rd_word = {8'h00, 8'(gap_width), 8'(pixel_width), 8'(num_pixels)};
            csr_addr_ctrl: rd_word[0] = enable;
            csr_addr_gap: begin
                rd_word[0 +: gap_width]           = lfsr_mask;
                rd_word[gap_min_lsb +: gap_width] = gap_min;
            end
            default:       rd_word = '0;
        endcase
    end

    // read data only valid for the one cycle after the registered strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_readdata <= '0;
        end else begin
            csr_readdata <= rd_q ? rd_word : '0;
        end
    end

endmodule

// ==== hdl/pgm_packet_parser.sv ====
// video packet parser: classifies packets, pulls control fields, tracks beat index and frames
`timescale 1ns/100ps

module pgm_packet_parser (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 iut_valid,
    input  logic                                 iut_ready,
    input  logic                                 iut_sop,
    input  logic                                 iut_eop,
    input  pgm_video_pkg::pixel_beat_u           iut_data,
    input  logic                                 enable,
    output logic                                 data_beat,
    output logic                                 data_start,
    output logic [pgm_video_pkg::index_width-1:0] beat_index,
    output pgm_video_pkg::pixel_beat_u           beat_data,
    output logic [pgm_video_pkg::frame_width-1:0] frame_number,
    output logic [15:0]                          frame_width,
    output logic [15:0]                          frame_height,
    output logic [3:0]                           interlace
);
    import pgm_video_pkg::*;

    logic                      accept;
    logic                      sop_data;
    logic                      sop_ctrl;
    logic                      in_data;
    logic                      in_ctrl;
    logic [1:0]                ctrl_beat;
    logic [ctrl_nibbles*4-1:0] ctrl_fields;
    logic [index_width-1:0]    index_q;

    // ready latency zero, a beat counts when valid and ready are both high
    assign accept   = iut_valid & iut_ready;
    assign sop_data = accept & iut_sop & enable & (iut_data.ctrl.pkt_type == pkt_type_data);
    assign sop_ctrl = accept & iut_sop & enable & (iut_data.ctrl.pkt_type == pkt_type_ctrl);

    // zero latency view of the accepted data beats
    assign data_beat  = sop_data | (accept & in_data & ~iut_sop);
    assign beat_index = iut_sop ? '0 : index_q;
    assign beat_data  = iut_data;

    // **********************************************************
    // data packets
    // **********************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_data      <= 1'b0;
            data_start   <= 1'b0;
            index_q      <= '0;
            frame_number <= '0;
        end else begin
            data_start <= sop_data;
            if (accept & iut_eop) begin
                in_data <= 1'b0;
            end else if (sop_data) begin
                in_data <= 1'b1;
            end
            if (data_beat) begin
                index_q <= beat_index + 1'b1;
            end
            // frame count wraps at 128
            if (data_beat & iut_eop) begin
                frame_number <= frame_number + 1'b1;
            end
        end
    end

    // **********************************************************
    // control packets
    // **********************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_ctrl   <= 1'b0;
            ctrl_beat <= '0;
        end else begin
            if (accept & iut_eop) begin
                in_ctrl <= 1'b0;
            end else if (sop_ctrl) begin
                in_ctrl <= 1'b1;
            end
            // beats after sop, saturating once all nibbles are in
            if (sop_ctrl) begin
                ctrl_beat <= '0;
            end else if (accept & in_ctrl & (ctrl_beat != 2'd3)) begin
                ctrl_beat <= ctrl_beat + 1'b1;
            end
        end
    end

    // low nibble of each pixel, most significant nibble first
    always_ff @(posedge clk) begin : nibble_fill
        int k;
        if (accept & in_ctrl & ~iut_sop) begin
            for (int i = 0; i < num_pixels; i++) begin
                k = int'(ctrl_beat) * num_pixels + i;
                if (k < ctrl_nibbles) begin
                    ctrl_fields[(ctrl_nibbles - 1 - k) * 4 +: 4] <= iut_data.pixels[i][3:0];
                end
            end
        end
    end

    assign frame_width  = ctrl_fields[ctrl_nibbles*4-1 -: 16];
    assign frame_height = ctrl_fields[4 +: 16];
    assign interlace    = ctrl_fields[3:0];

endmodule

// ==== hdl/pgm_sample_ctrl.sv ====
// sample controller: lfsr plus gap countdown choosing which data beats are grabbed
`timescale 1ns/100ps

module pgm_sample_ctrl (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  data_beat,
    input  logic                                  data_start,
    input  logic [pgm_video_pkg::index_width-1:0] beat_index,
    input  logic [pgm_video_pkg::frame_width-1:0] frame_number,
    input  logic [pgm_video_pkg::gap_width-1:0]   lfsr_mask,
    input  logic [pgm_video_pkg::gap_width-1:0]   gap_min,
    output logic                                  sample_now,
    output logic [pgm_video_pkg::gap_width-1:0]   sample_gap
);
    import pgm_video_pkg::*;

    logic [lfsr_width-1:0]  lfsr;
    logic [index_width-1:0] next_index;
    logic [index_width-1:0] target;
    logic [gap_width-1:0]   gap_q;
    logic [gap_width-1:0]   first_gap;
    logic [gap_width-1:0]   rand_gap;

    // first sample of a frame is repeatable, keyed on the frame number
    assign first_gap = gap_width'(frame_number) & lfsr_mask;
    assign rand_gap  = lfsr[gap_width-1:0] & lfsr_mask;

    // beat 1 may arrive together with data_start
    assign target = data_start ? index_width'(gap_min) + index_width'(first_gap) : next_index;

    // sop beat has gone by before data_start, so index 0 never matches
    assign sample_now = data_beat & (beat_index != '0) & (beat_index == target);
    assign sample_gap = data_start ? first_gap : gap_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr       <= lfsr_seed;
            next_index <= '0;
            gap_q      <= '0;
        end else if (sample_now) begin
            // next index uses the lfsr value before it steps
            lfsr       <= {lfsr[lfsr_width-2:0], lfsr[lfsr_width-1] ^ lfsr[lfsr_width-4]};
            next_index <= beat_index + index_width'(gap_min) + index_width'(rand_gap) + 1'b1;
            gap_q      <= rand_gap;
        end else if (data_start) begin
            next_index <= target;
            gap_q      <= first_gap;
        end
    end

endmodule

// ==== hdl/pgm_trace_out.sv ====
// trace output: holds one sample record and sends it as a four word packet with drop flag
`timescale 1ns/100ps

module pgm_trace_out (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  sample_now,
    input  logic [pgm_video_pkg::index_width-1:0] beat_index,
    input  pgm_video_pkg::pixel_beat_u            beat_data,
    input  logic [pgm_video_pkg::frame_width-1:0] frame_number,
    input  logic [15:0]                           frame_width,
    input  logic [15:0]                           frame_height,
    input  logic [3:0]                            interlace,
    input  logic [pgm_video_pkg::gap_width-1:0]   gap_min,
    input  logic [pgm_video_pkg::gap_width-1:0]   sample_gap,
    input  logic                                  trace_ready,
    output logic                                  trace_valid,
    output logic                                  trace_sop,
    output logic                                  trace_eop,
    output logic [pgm_video_pkg::trace_width-1:0] trace_data
);
    import pgm_video_pkg::*;

    logic                           loaded;
    logic                           busy;
    logic                           drop_q;
    logic [$clog2(trace_words)-1:0] word_cnt;
    logic                           hdr_drop;
    logic [index_width-1:0]         index_r;
    logic [7:0]                     frame_r;
    logic [31:0]                    size_r;
    logic [3:0]                     ilace_r;
    logic [gap_width-1:0]           gap_min_r;
    logic [gap_width-1:0]           gap_r;
    pixel_beat_u                    beat_r;

    // a record is pending from capture until word 3 is taken
    assign busy = loaded | trace_valid;

    // **********************************************************
    // sample capture
    // **********************************************************
    always_ff @(posedge clk) begin
        if (sample_now & ~busy) begin
            hdr_drop  <= drop_q;
            index_r   <= beat_index;
            frame_r   <= 8'(frame_number);
            size_r    <= {frame_width, frame_height};
            ilace_r   <= interlace;
            gap_min_r <= gap_min;
            gap_r     <= sample_gap;
            beat_r    <= beat_data;
        end
    end

    // **********************************************************
    // packet sequencing
    // **********************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            loaded      <= 1'b0;
            trace_valid <= 1'b0;
            word_cnt    <= '0;
            drop_q      <= 1'b0;
        end else begin
            loaded <= sample_now & ~busy;
            // a sample while busy is lost, pending drops move into the next header
            if (sample_now) begin
                drop_q <= busy;
            end
            if (trace_valid & trace_ready) begin
                if (int'(word_cnt) == trace_words - 1) begin
                    trace_valid <= 1'b0;
                    word_cnt    <= '0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
            // word 0 shows one cycle after capture
            if (loaded) begin
                trace_valid <= 1'b1;
                word_cnt    <= '0;
            end
        end
    end

    assign trace_sop = trace_valid & (word_cnt == '0);
    assign trace_eop = trace_valid & (int'(word_cnt) == trace_words - 1);

    // word select, held while the sink stalls
    always_comb begin
        case (int'(word_cnt))
            0:       trace_data = {hdr_base | {7'd0, hdr_drop}, frame_r, 16'(index_r)};
            1:       trace_data = size_r;
            2:       trace_data = {16'(gap_min_r), 16'(gap_r)};
            default: trace_data = {ilace_r, 4'h0, beat_r.pixels};
        endcase
    end

endmodule

// ==== hdl/pixel_grabber_monitor.sv ====
// pixel grabber monitor top: register port, packet parser, sampler and trace output
`timescale 1ns/100ps

module pixel_grabber_monitor (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   iut_valid,
    input  logic                                   iut_ready,
    input  logic                                   iut_sop,
    input  logic                                   iut_eop,
    input  pgm_video_pkg::pixel_beat_u             iut_data,
    input  logic                                   csr_write,
    input  logic                                   csr_read,
    input  logic [pgm_csr_pkg::csr_addr_width-1:0] csr_address,
    input  logic [pgm_csr_pkg::csr_data_width-1:0] csr_write_data,
    output logic [pgm_csr_pkg::csr_data_width-1:0] csr_readdata,
    input  logic                                   trace_ready,
    output logic                                   trace_valid,
    output logic                                   trace_sop,
    output logic                                   trace_eop,
    output logic [pgm_video_pkg::trace_width-1:0]  trace_data
);
    import pgm_video_pkg::*;

    // video size from the latest control packet
    logic [15:0]                           frame_width;
    logic [15:0]                           frame_height;
    logic [3:0]                            interlace;
    logic [pgm_video_pkg::frame_width-1:0] frame_number;
    logic                                  enable;
    logic [gap_width-1:0]                  lfsr_mask;
    logic [gap_width-1:0]                  gap_min;
    logic                                  data_beat;
    logic                                  data_start;
    logic [index_width-1:0]                beat_index;
    pixel_beat_u                           beat_data;
    logic                                  sample_now;
    logic [gap_width-1:0]                  sample_gap;

    pgm_csr pgm_csr_inst (.*);

    pgm_packet_parser pgm_packet_parser_inst (.*);

    pgm_sample_ctrl pgm_sample_ctrl_inst (.*);

    pgm_trace_out pgm_trace_out_inst (.*);

endmodule

// ==== tests/pixel_grabber_monitor_tb.sv ====
// pixel grabber monitor testbench that replays a golden command file
`timescale 1ns/100ps

module pixel_grabber_monitor_tb;
    import pgm_video_pkg::*;
    import pgm_csr_pkg::*;

    // slack for reset and the last drain
    localparam int margin_cycles = 200;

    logic                      clk;
    logic                      arst_n;
    logic                      iut_valid;
    logic                      iut_ready;
    logic                      iut_sop;
    logic                      iut_eop;
    pixel_beat_u               iut_data;
    logic                      csr_write;
    logic                      csr_read;
    logic [csr_addr_width-1:0] csr_address;
    logic [csr_data_width-1:0] csr_write_data;
    logic [csr_data_width-1:0] csr_readdata;
    logic                      trace_ready;
    logic                      trace_valid;
    logic                      trace_sop;
    logic                      trace_eop;
    logic [trace_width-1:0]    trace_data;

    int                                 error_count = 0;
    int                                 budget_cycles = margin_cycles;
    int                                 cycle_count = 0;
    // beats of the latest data packet indexed by beat number
    pixel_beat_u                        sent_beats[0:255];
    // finished trace packets with word 0 in the top bits
    logic [trace_words*trace_width-1:0] trace_q[$];

    pixel_grabber_monitor pixel_grabber_monitor_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ************************************************************
    // compare tasks
    // ************************************************************
    task automatic check_word(input string name, input logic [trace_width-1:0] got,
                              input logic [trace_width-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_beat(input string name, input pixel_beat_u got, input pixel_beat_u exp);
        if (got.pixels !== exp.pixels) begin
            $display("MISMATCH at %0t ns: %s got %06h expected %06h", $time, name,
                     got.pixels, exp.pixels);
            error_count++;
        end
    endtask

    // ************************************************************
    // stimulus tasks
    // ************************************************************
    task automatic write_reg(input logic [csr_addr_width-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_write      <= 1'b1;
        csr_address    <= addr;
        csr_write_data <= data;
        @(posedge clk);
        csr_write <= 1'b0;
        // field lands on this edge
        @(posedge clk);
    endtask

    task automatic read_reg(input logic [csr_addr_width-1:0] addr, input logic [31:0] exp);
        @(posedge clk);
        csr_read    <= 1'b1;
        csr_address <= addr;
        @(posedge clk);
        csr_read <= 1'b0;
        // still zero while the strobe sits in the register stage
        @(negedge clk);
        check_word("csr_readdata", csr_readdata, '0);
        // read word shows two edges after the strobe
        @(posedge clk);
        @(negedge clk);
        check_word("csr_readdata", csr_readdata, exp);
        // back to zero one cycle later
        @(negedge clk);
        check_word("csr_readdata", csr_readdata, '0);
    endtask

    task automatic send_ctrl(input logic [15:0] width, input logic [15:0] height,
                             input logic [3:0] ilace);
        logic [ctrl_nibbles*4-1:0] nibs;
        pixel_beat_u               beat;
        int                        n;
        nibs = {width, height, ilace};
        for (int k = 0; k <= ctrl_nibbles / num_pixels; k++) begin
            beat = '0;
            if (k == 0) begin
                beat.ctrl.pkt_type = pkt_type_ctrl;
            end else begin
                // most significant nibble first into the low nibble of each pixel
                for (int i = 0; i < num_pixels; i++) begin
                    n = (k - 1) * num_pixels + i;
                    beat.pixels[i][3:0] = nibs[(ctrl_nibbles - 1 - n) * 4 +: 4];
                end
            end
            @(posedge clk);
            iut_valid <= 1'b1;
            iut_sop   <= (k == 0);
            iut_eop   <= (k == ctrl_nibbles / num_pixels);
            iut_data  <= beat;
        end
        @(posedge clk);
        iut_valid <= 1'b0;
        iut_sop   <= 1'b0;
        iut_eop   <= 1'b0;
    endtask

    task automatic send_data(input int len, input logic [23:0] salt, input int stall_at,
                             input int stall_len);
        logic [31:0] rnd;
        pixel_beat_u beat;
        int          wait_cycles;
        for (int i = 0; i < len; i++) begin
            rnd  = $urandom();
            beat = rnd[23:0] ^ salt;
            if (i == 0) begin
                beat.ctrl.pkt_type = pkt_type_data;
            end
            sent_beats[i] = beat;
            @(posedge clk);
            iut_valid   <= 1'b1;
            iut_sop     <= (i == 0);
            iut_eop     <= (i == len - 1);
            iut_data    <= beat;
            // sink stall window counted in beats
            trace_ready <= !(i >= stall_at && i < stall_at + stall_len);
        end
        @(posedge clk);
        iut_valid   <= 1'b0;
        iut_sop     <= 1'b0;
        iut_eop     <= 1'b0;
        trace_ready <= 1'b1;
        // a sample on the eop beat shows up two edges later
        repeat (3) @(negedge clk);
        wait_cycles = 0;
        while (trace_valid && wait_cycles < 64) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (trace_valid) begin
            $display("ERROR at %0t ns: trace output still busy long after the packet", $time);
            error_count++;
        end
    endtask

    task automatic check_trace(input logic [31:0] w0, input logic [31:0] w1,
                               input logic [31:0] w2, input logic [7:0] top);
        logic [trace_words*trace_width-1:0] pkt;
        if (trace_q.size() == 0) begin
            $display("ERROR at %0t ns: no trace packet for beat index %0d", $time, w0[15:0]);
            error_count++;
        end else begin
            pkt = trace_q.pop_front();
            check_word("trace_data word 0", pkt[3*trace_width +: trace_width], w0);
            check_word("trace_data word 1", pkt[2*trace_width +: trace_width], w1);
            check_word("trace_data word 2", pkt[trace_width +: trace_width], w2);
            check_word("trace_data word 3 top byte", {pkt[31:24], 24'h0}, {top, 24'h0});
            // beat index comes from the expected word 0
            check_beat("trace_data word 3 beat", pkt[23:0], sent_beats[w0[7:0]]);
        end
    endtask

    // trace words are taken at the falling edge
    initial begin : trace_collect
        int                                 pos;
        logic [trace_words*trace_width-1:0] pkt;
        pos = 0;
        pkt = '0;
        forever begin
            @(negedge clk);
            if (trace_valid && trace_ready) begin
                if (trace_sop !== (pos == 0) || trace_eop !== (pos == trace_words - 1)) begin
                    $display("ERROR at %0t ns: trace_sop or trace_eop wrong at word %0d",
                             $time, pos);
                    error_count++;
                end
                pkt[(trace_words - 1 - pos) * trace_width +: trace_width] = trace_data;
                if (pos == trace_words - 1) begin
                    trace_q.push_back(pkt);
                    pos = 0;
                end else begin
                    pos++;
                end
            end
        end
    end

    // budget grows as each command is read
    initial begin : watchdog
        while (cycle_count <= budget_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run took more than %0d cycles, stimulus did not finish", budget_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ************************************************************
    // golden file command loop
    // ************************************************************
    initial begin : run_golden
        int               fd;
        int               code;
        int               test_num;
        int               errors_before;
        logic [7:0]       cmd;
        logic [31:0]      a0;
        logic [31:0]      a1;
        logic [31:0]      a2;
        logic [31:0]      a3;
        logic [8*128-1:0] rest;
        void'($urandom(32'h60ec_cf7b));
        arst_n         = 1'b0;
        iut_valid      = 1'b0;
        iut_ready      = 1'b1;
        iut_sop        = 1'b0;
        iut_eop        = 1'b0;
        iut_data       = '0;
        csr_write      = 1'b0;
        csr_read       = 1'b0;
        csr_address    = '0;
        csr_write_data = '0;
        trace_ready    = 1'b1;
        test_num       = 0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("tests/pgm_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tests/pgm_golden.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", cmd);
                if (code == 1 && cmd == "#") begin
                    code = $fgets(rest, fd);
                end else if (code == 1) begin
                    test_num++;
                    errors_before = error_count;
                    case (cmd)
                        "W": begin
                            code = $fscanf(fd, "%h %h", a0, a1);
                            budget_cycles += 16;
                            write_reg(a0[csr_addr_width-1:0], a1);
                        end
                        "R": begin
                            code = $fscanf(fd, "%h %h", a0, a1);
                            budget_cycles += 16;
                            read_reg(a0[csr_addr_width-1:0], a1);
                        end
                        "C": begin
                            code = $fscanf(fd, "%h %h %h", a0, a1, a2);
                            budget_cycles += 4 * 4;
                            send_ctrl(a0[15:0], a1[15:0], a2[3:0]);
                        end
                        "D": begin
                            code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
                            budget_cycles += 4 * (int'(a0) + int'(a3)) + 16;
                            send_data(int'(a0), a1[23:0], int'(a2), int'(a3));
                        end
                        "T": begin
                            code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
                            check_trace(a0, a1, a2, a3[7:0]);
                        end
                        "E": begin
                            if (trace_q.size() != 0) begin
                                $display("ERROR at %0t ns: %0d trace packets more than expected",
                                         $time, trace_q.size());
                                error_count++;
                                trace_q.delete();
                            end
                        end
                        default: begin
                            $display("ERROR: unknown golden command %c", cmd);
                            error_count++;
                        end
                    endcase
                    $display("test %0d (%c): %s", test_num, cmd,
                             (error_count == errors_before) ? "ok" : "FAILED");
                end
            end
            $fclose(fd);
        end
        $display("tests run %0d, errors %0d", test_num, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/pgm_golden.txt ====
# one command per line, all fields hex: W addr data | R addr expected | C width height interlace
# D length pixel_salt stall_at stall_len | T word0 word1 word2 word3_top_byte | E no trace left
R 0 0011006e
R 2 000e0803
W 5 0006003f
R 5 0006003f
R 4 00000000
R 7 00000000
# enable low, packet is ignored
D 10 a5a5a5 0 0
E
W 4 00000001
R 4 00000001
C 0280 01e0 2
D 28 000000 0 0
T 80000006 028001e0 00060000 20
T 8000000e 028001e0 00060001 20
T 80000017 028001e0 00060002 20
T 80000022 028001e0 00060004 20
E
D 30 5a5a5a 0 0
T 80010007 028001e0 00060001 20
T 8001001e 028001e0 00060010 20
E
C 0780 0438 1
# trace_ready low across the sample at index 15
D 20 3c3c3c a 6
T 80020008 07800438 00060002 10
T 81020016 07800438 00060000 10
T 8002001d 07800438 00060000 10
E

// ==== sim.f ====
hdl/pgm_video_pkg.sv
hdl/pgm_csr_pkg.sv
hdl/pgm_csr.sv
hdl/pgm_packet_parser.sv
hdl/pgm_sample_ctrl.sv
hdl/pgm_trace_out.sv
hdl/pixel_grabber_monitor.sv
tests/pixel_grabber_monitor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the pixel grabber monitor testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sim.f \
        --top-module pixel_grabber_monitor_tb -o pgm_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/pgm_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation finished: PASS" <<< "$output"; then
    exit 0
fi
exit 1
